/* lb_consts.svh */
// Loopback exerciser constants: engine count, widths, block and region sizes, pattern salt
`ifndef LB_CONSTS_SVH
`define LB_CONSTS_SVH

// ========================================
// Topology
// ========================================

// Number of test engines sharing the host port
`define LB_NUM_ENGINES 2

// ========================================
// Bus widths
// ========================================

// Word address, not byte address
`define LB_ADDR_W 8
`define LB_DATA_W 32

// ========================================
// Test block layout
// ========================================

// Words written and read per engine run
`define LB_WORDS 8
// Each engine owns a region of this many words
`define LB_REGION_WORDS 16
// Expected word at address a is a + salt
`define LB_PATTERN_SALT 32'h5A5A_0000

// Mismatch counter width, saturating
`define LB_ERR_W 4

`endif

/* lb_pkg.sv */
// Shared types: AXI-MM channel payloads, request and response bundles, engine state and opcode
`include "lb_consts.svh"

package lb_pkg;

    // ========================================
    // AXI channel payloads
    // ========================================

    // Write address, single beat
    typedef struct packed {
        logic [`LB_ADDR_W-1:0] addr;
    } axi_aw_t;

    // Write data, no strobes
    typedef struct packed {
        logic [`LB_DATA_W-1:0] data;
    } axi_w_t;

    // Write response, memory always reports okay
    typedef struct packed {
        logic okay;
    } axi_b_t;

    // Read address
    typedef struct packed {
        logic [`LB_ADDR_W-1:0] addr;
    } axi_ar_t;

    // Read data
    typedef struct packed {
        logic [`LB_DATA_W-1:0] data;
    } axi_r_t;

    // ========================================
    // Bundles per direction
    // ========================================

    // Everything the master drives
    typedef struct packed {
        logic    awvalid;
        axi_aw_t aw;
        logic    wvalid;
        axi_w_t  w;
        logic    bready;
        logic    arvalid;
        axi_ar_t ar;
        logic    rready;
    } axi_req_t;

    // Everything the slave drives
    typedef struct packed {
        logic    awready;
        logic    wready;
        logic    bvalid;
        axi_b_t  b;
        logic    arready;
        logic    rvalid;
        axi_r_t  r;
    } axi_rsp_t;

    // ========================================
    // Engine control
    // ========================================

    typedef enum logic {
        OP_WRITE_READ = 1'b0,
        OP_READ_CHECK = 1'b1
    } lb_opcode_e;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_WR_ADDR = 3'd1,
        ST_WR_RESP = 3'd2,
        ST_RD_ADDR = 3'd3,
        ST_RD_DATA = 3'd4,
        ST_DONE    = 3'd5
    } lb_state_e;

endpackage

/* axi_skid_buffer.sv */
// Two-entry skid buffer for a single valid/ready channel with a generic payload type
`timescale 1ns/10ps

module axi_skid_buffer
    #(
        parameter type T = logic
    )
    (
        input  logic clk,
        input  logic rst_n,

        // Upstream side
        input  logic in_valid,
        input  T     in_data,
        output logic in_ready,

        // Downstream side
        output logic out_valid,
        output T     out_data,
        input  logic out_ready
    );

    // Spare entry catches the beat that arrives while the output stalls
    logic spare_valid;
    T     spare_data;

    // Main register may load this cycle
    logic main_free;

    assign main_free = out_ready || !out_valid;

    // Registered ready, low only while the spare is occupied
    assign in_ready = !spare_valid;

    // Control state
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
        end
        else if (main_free)
        begin
            // Spare drains first, input is blocked while it is full
            if (spare_valid)
            begin
                out_valid   <= 1'b1;
                spare_valid <= 1'b0;
            end
            else
            begin
                out_valid <= in_valid;
            end
        end
        else if (in_valid && !spare_valid)
        begin
            // Output stalled, park the incoming beat
            spare_valid <= 1'b1;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            out_data <= spare_valid ? spare_data : in_data;
        end
        else if (in_valid && !spare_valid)
        begin
            spare_data <= in_data;
        end
    end

    // Stalled output must keep its payload until the transfer
    a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* lb_test_engine.sv */
// Test engine: writes a patterned block, reads it back and counts mismatches
`timescale 1ns/10ps
`include "lb_consts.svh"

module lb_test_engine
    import lb_pkg::*;
    (
        input  logic                 clk,
        input  logic                 rst_n,

        // Control from the parent
        input  logic                 start,
        input  lb_opcode_e           opcode,
        input  logic [`LB_ADDR_W-1:0] base_addr,

        // AXI-MM master port
        output axi_req_t             mem_req,
        input  axi_rsp_t             mem_rsp,

        // Status
        output logic                 busy,
        output logic                 done,
        output logic [`LB_ERR_W-1:0] error_count
    );

    localparam int IDX_W = $clog2(`LB_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`LB_WORDS - 1);

    lb_state_e state;
    logic [IDX_W-1:0] word_idx;
    // Write address and data may transfer in different cycles
    logic aw_done;
    logic w_done;

    logic [`LB_ADDR_W-1:0] cur_addr;
    logic [`LB_DATA_W-1:0] pattern;
    logic aw_xfer;
    logic w_xfer;

    assign cur_addr = base_addr + `LB_ADDR_W'(word_idx);
    assign pattern  = `LB_DATA_W'(cur_addr) + `LB_PATTERN_SALT;

    assign busy = (state != ST_IDLE) && (state != ST_DONE);
    assign done = (state == ST_DONE);

    // ========================================
    // Request side
    // ========================================

    always_comb
    begin
        mem_req         = '0;
        mem_req.awvalid = (state == ST_WR_ADDR) && !aw_done;
        mem_req.aw.addr = cur_addr;
        mem_req.wvalid  = (state == ST_WR_ADDR) && !w_done;
        mem_req.w.data  = pattern;
        mem_req.arvalid = (state == ST_RD_ADDR);
        mem_req.ar.addr = cur_addr;
        // Responses are always accepted
        mem_req.bready  = 1'b1;
        mem_req.rready  = 1'b1;
    end

    assign aw_xfer = mem_req.awvalid && mem_rsp.awready;
    assign w_xfer  = mem_req.wvalid && mem_rsp.wready;

    // ========================================
    // Sequencer
    // ========================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= ST_IDLE;
            word_idx    <= '0;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            error_count <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE, ST_DONE:
                begin
                    if (start)
                    begin
                        word_idx    <= '0;
                        error_count <= '0;
                        state       <= (opcode == OP_WRITE_READ) ? ST_WR_ADDR : ST_RD_ADDR;
                    end
                end
                ST_WR_ADDR:
                begin
                    // Both halves of the write must have gone out
                    if ((aw_done || aw_xfer) && (w_done || w_xfer))
                    begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= ST_WR_RESP;
                    end
                    else
                    begin
                        aw_done <= aw_done || aw_xfer;
                        w_done  <= w_done || w_xfer;
                    end
                end
                ST_WR_RESP:
                begin
                    if (mem_rsp.bvalid)
                    begin
                        // Last write done, read the block back from the start
                        word_idx <= (word_idx == LAST_IDX) ? '0 : word_idx + 1'b1;
                        state    <= (word_idx == LAST_IDX) ? ST_RD_ADDR : ST_WR_ADDR;
                    end
                end
                ST_RD_ADDR:
                begin
                    if (mem_rsp.arready)
                    begin
                        state <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA:
                begin
                    if (mem_rsp.rvalid)
                    begin
                        // Saturating mismatch count
                        if ((mem_rsp.r.data != pattern) && (error_count != '1))
                        begin
                            error_count <= error_count + 1'b1;
                        end
                        word_idx <= word_idx + 1'b1;
                        state    <= (word_idx == LAST_IDX) ? ST_DONE : ST_RD_ADDR;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Parent may only start an idle or finished engine
    a_no_start_busy : assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

/* lb_mux_fixed.sv */
// Fixed-select AXI-MM multiplexer with per-port skid buffers and response demux
`timescale 1ns/10ps

module lb_mux_fixed
    import lb_pkg::*;
    #(
        parameter int NUM_PORTS = 2
    )
    (
        input  logic clk,
        input  logic rst_n,

        // Chosen port, held by the parent while that port is busy
        input  logic [$clog2(NUM_PORTS)-1:0] port_select,

        // Engine side, one bundle per port
        input  axi_req_t port_req [NUM_PORTS],
        output axi_rsp_t port_rsp [NUM_PORTS],

        // Memory side
        output axi_req_t merged_req,
        input  axi_rsp_t merged_rsp
    );

    // Mux side of the skid buffers, indexed by port
    logic    mux_awvalid [NUM_PORTS];
    axi_aw_t mux_aw      [NUM_PORTS];
    logic    mux_wvalid  [NUM_PORTS];
    axi_w_t  mux_w       [NUM_PORTS];
    logic    mux_bready  [NUM_PORTS];
    logic    mux_arvalid [NUM_PORTS];
    axi_ar_t mux_ar      [NUM_PORTS];
    logic    mux_rready  [NUM_PORTS];

    // ========================================
    // Per-port skid buffers
    // ========================================

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_port
        logic   aw_rdy;
        logic   w_rdy;
        logic   ar_rdy;
        logic   b_vld;
        axi_b_t b_dat;
        logic   r_vld;
        axi_r_t r_dat;
        // Responses are only offered to the selected port
        logic   is_sel;

        assign is_sel = (port_select == p);

        // Requests toward memory, ready fans out so unselected traffic drains away
        axi_skid_buffer #(.T(axi_aw_t)) u_aw_skid (
            .clk(clk), .rst_n(rst_n),
            .in_valid(port_req[p].awvalid), .in_data(port_req[p].aw), .in_ready(aw_rdy),
            .out_valid(mux_awvalid[p]), .out_data(mux_aw[p]), .out_ready(merged_rsp.awready)
        );
        axi_skid_buffer #(.T(axi_w_t)) u_w_skid (
            .clk(clk), .rst_n(rst_n),
            .in_valid(port_req[p].wvalid), .in_data(port_req[p].w), .in_ready(w_rdy),
            .out_valid(mux_wvalid[p]), .out_data(mux_w[p]), .out_ready(merged_rsp.wready)
        );
        axi_skid_buffer #(.T(axi_ar_t)) u_ar_skid (
            .clk(clk), .rst_n(rst_n),
            .in_valid(port_req[p].arvalid), .in_data(port_req[p].ar), .in_ready(ar_rdy),
            .out_valid(mux_arvalid[p]), .out_data(mux_ar[p]), .out_ready(merged_rsp.arready)
        );

        // Responses back, payload broadcast and valid gated by the select
        axi_skid_buffer #(.T(axi_b_t)) u_b_skid (
            .clk(clk), .rst_n(rst_n),
            .in_valid(merged_rsp.bvalid && is_sel), .in_data(merged_rsp.b),
            .in_ready(mux_bready[p]),
            .out_valid(b_vld), .out_data(b_dat), .out_ready(port_req[p].bready)
        );
        axi_skid_buffer #(.T(axi_r_t)) u_r_skid (
            .clk(clk), .rst_n(rst_n),
            .in_valid(merged_rsp.rvalid && is_sel), .in_data(merged_rsp.r),
            .in_ready(mux_rready[p]),
            .out_valid(r_vld), .out_data(r_dat), .out_ready(port_req[p].rready)
        );

        assign port_rsp[p] = '{awready: aw_rdy, wready: w_rdy, bvalid: b_vld, b: b_dat,
                               arready: ar_rdy, rvalid: r_vld, r: r_dat};
    end

    // ========================================
    // Select the active port toward memory
    // ========================================

    always_comb
    begin
        merged_req.awvalid = mux_awvalid[port_select];
        merged_req.aw      = mux_aw[port_select];
        merged_req.wvalid  = mux_wvalid[port_select];
        merged_req.w       = mux_w[port_select];
        merged_req.bready  = mux_bready[port_select];
        merged_req.arvalid = mux_arvalid[port_select];
        merged_req.ar      = mux_ar[port_select];
        merged_req.rready  = mux_rready[port_select];
    end

    // Switching ports under a stalled request would break the AXI hold rule
    a_sel_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (merged_req.awvalid && !merged_rsp.awready) ||
        (merged_req.arvalid && !merged_rsp.arready) |=> $stable(port_select));

endmodule

/* host_mem_model.sv */
// Host memory model: single-beat AXI-MM slave over a reset-cleared word array
`timescale 1ns/10ps
`include "lb_consts.svh"

module host_mem_model
    import lb_pkg::*;
    (
        input  logic     clk,
        input  logic     rst_n,

        input  axi_req_t mem_req,
        output axi_rsp_t mem_rsp
    );

    localparam int DEPTH = `LB_NUM_ENGINES * `LB_REGION_WORDS;
    localparam int IDX_W = $clog2(DEPTH);

    logic [`LB_DATA_W-1:0] mem [DEPTH];

    // Write side, address and data may arrive apart
    logic aw_got;
    logic w_got;
    logic [`LB_ADDR_W-1:0] aw_addr_q;
    logic [`LB_DATA_W-1:0] w_data_q;
    logic b_valid;

    // Read side
    logic r_valid;
    logic [`LB_DATA_W-1:0] r_data;

    logic aw_xfer;
    logic w_xfer;
    logic ar_xfer;
    logic wr_commit;
    logic [`LB_ADDR_W-1:0] wr_addr;
    logic [`LB_DATA_W-1:0] wr_data;

    // ========================================
    // Handshakes
    // ========================================

    assign aw_xfer = mem_req.awvalid && mem_rsp.awready;
    assign w_xfer  = mem_req.wvalid && mem_rsp.wready;
    assign ar_xfer = mem_req.arvalid && mem_rsp.arready;

    // Commit once both halves are in hand
    assign wr_commit = (aw_got || aw_xfer) && (w_got || w_xfer);
    assign wr_addr   = aw_xfer ? mem_req.aw.addr : aw_addr_q;
    assign wr_data   = w_xfer ? mem_req.w.data : w_data_q;

    always_comb
    begin
        mem_rsp         = '0;
        // No new write while a response is outstanding
        mem_rsp.awready = !b_valid && !aw_got;
        mem_rsp.wready  = !b_valid && !w_got;
        mem_rsp.bvalid  = b_valid;
        mem_rsp.b.okay  = 1'b1;
        mem_rsp.arready = !r_valid;
        mem_rsp.rvalid  = r_valid;
        mem_rsp.r.data  = r_data;
    end

    // ========================================
    // Control state
    // ========================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end
        else
        begin
            if (wr_commit)
            begin
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                b_valid <= 1'b1;
            end
            else
            begin
                aw_got <= aw_got || aw_xfer;
                w_got  <= w_got || w_xfer;
                if (b_valid && mem_req.bready)
                begin
                    b_valid <= 1'b0;
                end
            end

            // Read data one cycle after the address
            if (ar_xfer)
            begin
                r_valid <= 1'b1;
            end
            else if (r_valid && mem_req.rready)
            begin
                r_valid <= 1'b0;
            end
        end
    end

    // Held halves of a split write
    always_ff @(posedge clk)
    begin
        if (aw_xfer)
        begin
            aw_addr_q <= mem_req.aw.addr;
        end
        if (w_xfer)
        begin
            w_data_q <= mem_req.w.data;
        end
        if (ar_xfer)
        begin
            r_data <= mem[mem_req.ar.addr[IDX_W-1:0]];
        end
    end

    // Storage, cleared so untouched regions read as zero
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (wr_commit)
        begin
            mem[wr_addr[IDX_W-1:0]] <= wr_data;
        end
    end

    // A write response only follows a completed write
    a_b_after_write : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_rsp.bvalid) |-> $past(wr_commit));

endmodule

/* lb_exerciser_top.sv */
// Top level: test engines, fixed-select mux and host memory model
`timescale 1ns/10ps
`include "lb_consts.svh"

module lb_exerciser_top
    import lb_pkg::*;
    (
        input  logic                       clk,
        input  logic                       rst_n,

        // Engine owning the memory port
        input  logic [$clog2(`LB_NUM_ENGINES)-1:0] port_select,

        // Per-engine control and status
        input  logic [`LB_NUM_ENGINES-1:0] start,
        input  lb_opcode_e                 opcode      [`LB_NUM_ENGINES],
        output logic [`LB_NUM_ENGINES-1:0] busy,
        output logic [`LB_NUM_ENGINES-1:0] done,
        output logic [`LB_ERR_W-1:0]       error_count [`LB_NUM_ENGINES]
    );

    // Engine ports and the merged memory port
    axi_req_t eng_req [`LB_NUM_ENGINES];
    axi_rsp_t eng_rsp [`LB_NUM_ENGINES];
    axi_req_t mem_req;
    axi_rsp_t mem_rsp;

    // ========================================
    // Input side: one engine per region
    // ========================================

    for (genvar n = 0; n < `LB_NUM_ENGINES; n++)
    begin : g_eng
        lb_test_engine u_engine (
            .clk(clk),
            .rst_n(rst_n),
            .start(start[n]),
            .opcode(opcode[n]),
            // Region base is a constant per instance
            .base_addr(`LB_ADDR_W'(n * `LB_REGION_WORDS)),
            .mem_req(eng_req[n]),
            .mem_rsp(eng_rsp[n]),
            .busy(busy[n]),
            .done(done[n]),
            .error_count(error_count[n])
        );
    end

    // Processing: no arbitration, only the selected engine reaches memory
    lb_mux_fixed #(.NUM_PORTS(`LB_NUM_ENGINES)) u_mux (
        .clk(clk),
        .rst_n(rst_n),
        .port_select(port_select),
        .port_req(eng_req),
        .port_rsp(eng_rsp),
        .merged_req(mem_req),
        .merged_rsp(mem_rsp)
    );

    // Output side
    host_mem_model u_mem (
        .clk(clk),
        .rst_n(rst_n),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

/* tb_lb_exerciser.sv */
// Loopback exerciser testbench with clock, reset, engine runs, scoreboard, assertions and watchdog
`timescale 1ns/10ps
`include "lb_consts.svh"

module tb_lb_exerciser
    import lb_pkg::*;
    ();

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_ROUNDS   = 6;
    localparam int STALL_CYCLES = 200;
    // Roughly 4 cycles per word in each pass
    // Limit is twice a full write-and-read run
    localparam int RUN_LIMIT    = 4 * 4 * `LB_WORDS;
    // Fixed sequence starts 9 runs before the random rounds
    localparam int NUM_RUNS     = 9 + NUM_ROUNDS;
    localparam int WATCHDOG_NS  =
        (NUM_RUNS * RUN_LIMIT + STALL_CYCLES + 8 * NUM_ROUNDS + 50) * CLK_PERIOD;
    localparam int MEM_WORDS    = `LB_NUM_ENGINES * `LB_REGION_WORDS;

    // DUT inputs
    logic                                 clk;
    logic                                 rst_n;
    logic [$clog2(`LB_NUM_ENGINES)-1:0]   port_select;
    logic [`LB_NUM_ENGINES-1:0]           start;
    lb_opcode_e                           opcode      [`LB_NUM_ENGINES];

    // DUT outputs
    logic [`LB_NUM_ENGINES-1:0]           busy;
    logic [`LB_NUM_ENGINES-1:0]           done;
    logic [`LB_ERR_W-1:0]                 error_count [`LB_NUM_ENGINES];

    // Scoreboard of expected memory contents and results per engine
    logic [`LB_DATA_W-1:0] exp_mem [MEM_WORDS];
    int                    exp_err [`LB_NUM_ENGINES];
    lb_opcode_e            last_op [`LB_NUM_ENGINES];

    int  errors;
    int  checks;
    int  runs;
    // High while the unselected engine must stay stuck
    logic stall_watch;

    lb_exerciser_top u_dut (
        .clk(clk),
        .rst_n(rst_n),
        .port_select(port_select),
        .start(start),
        .opcode(opcode),
        .busy(busy),
        .done(done),
        .error_count(error_count)
    );

    // ========================================
    // Clock and watchdog
    // ========================================

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, an engine never finished", WATCHDOG_NS);
        $display("Summary: %0d runs, %0d checks, %0d errors", runs, checks, errors + 1);
        $display("Simulation failed");
        $finish;
    end

    // ========================================
    // Concurrent checks
    // ========================================

    for (genvar n = 0; n < `LB_NUM_ENGINES; n++)
    begin : g_chk
        // Result is final once done rises
        a_done_errors : assert property (@(posedge clk) disable iff (!rst_n)
            $rose(done[n]) |-> (error_count[n] == exp_err[n]))
        else
        begin
            errors = errors + 1;
            $display("[FAIL] %0t error_count[%0d] expected %0d got %0d",
                     $time, n, exp_err[n], error_count[n]);
        end

        // Done holds until the next start
        a_done_hold : assert property (@(posedge clk) disable iff (!rst_n)
            done[n] && !start[n] |=> done[n])
        else
        begin
            errors = errors + 1;
            $display("[FAIL] %0t done[%0d] expected 1 got %0b", $time, n, done[n]);
        end
    end

    // Engine 1 gets no responses while port 0 is selected
    a_stall_hold : assert property (@(posedge clk) disable iff (!rst_n)
        stall_watch |-> (busy[1] && !done[1]))
    else
    begin
        errors = errors + 1;
        $display("[FAIL] %0t busy[1]/done[1] expected 1/0 got %0b/%0b",
                 $time, busy[1], done[1]);
    end

    // ========================================
    // Helpers
    // ========================================

    task automatic check_value(input string name, input int got, input int exp);
        checks = checks + 1;
        assert (got == exp)
        else
        begin
            errors = errors + 1;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // Block words not holding their pattern
    // Saturates at the counter maximum
    function automatic int expected_errors(input int n);
        int cnt;
        int addr;
        cnt = 0;
        for (int i = 0; i < `LB_WORDS; i++)
        begin
            addr = n * `LB_REGION_WORDS + i;
            if (exp_mem[addr] != (`LB_DATA_W'(addr) + `LB_PATTERN_SALT))
            begin
                cnt++;
            end
        end
        if (cnt > (1 << `LB_ERR_W) - 1)
        begin
            cnt = (1 << `LB_ERR_W) - 1;
        end
        return cnt;
    endfunction

    task automatic mark_block_written(input int n);
        int addr;
        for (int i = 0; i < `LB_WORDS; i++)
        begin
            addr = n * `LB_REGION_WORDS + i;
            exp_mem[addr] = `LB_DATA_W'(addr) + `LB_PATTERN_SALT;
        end
    endtask

    // Reset clears memory and the scoreboard with it
    task automatic apply_reset();
        rst_n = 1'b0;
        start = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            exp_mem[a] = '0;
        end
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        for (int n = 0; n < `LB_NUM_ENGINES; n++)
        begin
            exp_err[n] = 0;
            check_value($sformatf("error_count[%0d]", n), error_count[n], 0);
        end
    endtask

    // Single start pulse issued 1 ns after a rising edge
    task automatic launch_engine(input int n, input lb_opcode_e op);
        exp_err[n] = (op == OP_WRITE_READ) ? 0 : expected_errors(n);
        last_op[n] = op;
        opcode[n]  = op;
        start[n]   = 1'b1;
        @(posedge clk);
        #1;
        start[n]   = 1'b0;
        runs = runs + 1;
    endtask

    task automatic wait_done(input int n);
        int cycles;
        cycles = 0;
        while (!done[n] && cycles < RUN_LIMIT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done[n])
        begin
            errors = errors + 1;
            $display("Engine %0d did not finish within %0d cycles", n, RUN_LIMIT);
        end
        else if (last_op[n] == OP_WRITE_READ)
        begin
            mark_block_written(n);
        end
        // Let the done assertion sample before the next launch
        @(posedge clk);
        #1;
    endtask

    task automatic run_engine(input int n, input lb_opcode_e op);
        launch_engine(n, op);
        wait_done(n);
    endtask

    // ========================================
    // Stimulus
    // ========================================

    initial
    begin
        int         gap;
        int         eng;
        lb_opcode_e op;

        void'($urandom(14));
        errors      = 0;
        checks      = 0;
        runs        = 0;
        stall_watch = 1'b0;
        rst_n       = 1'b0;
        port_select = '0;
        start       = '0;
        for (int n = 0; n < `LB_NUM_ENGINES; n++)
        begin
            opcode[n]  = OP_READ_CHECK;
            last_op[n] = OP_READ_CHECK;
            exp_err[n] = 0;
        end

        // Reset values
        apply_reset();

        // Untouched region reads as zero so every word mismatches
        port_select = 0;
        run_engine(0, OP_READ_CHECK);

        // Write then verify the block of engine 0
        run_engine(0, OP_WRITE_READ);
        run_engine(0, OP_READ_CHECK);

        // Unselected engine loses its responses and stays busy
        launch_engine(1, OP_WRITE_READ);
        stall_watch = 1'b1;
        repeat (STALL_CYCLES) @(posedge clk);
        #1;
        stall_watch = 1'b0;
        run_engine(0, OP_READ_CHECK);

        // Engine 1 takes the port after reset
        // Engine 0 region must stay intact
        apply_reset();
        run_engine(0, OP_WRITE_READ);
        port_select = 1;
        run_engine(1, OP_WRITE_READ);
        run_engine(1, OP_READ_CHECK);
        port_select = 0;
        run_engine(0, OP_READ_CHECK);

        // Random idle gaps with alternating selection
        apply_reset();
        for (int r = 0; r < NUM_ROUNDS; r++)
        begin
            eng = r % `LB_NUM_ENGINES;
            op  = (r >= 2 && r < 4) ? OP_WRITE_READ : OP_READ_CHECK;
            gap = $urandom % 8;
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
            port_select = eng;
            run_engine(eng, op);
        end

        // Final results against the scoreboard
        for (int n = 0; n < `LB_NUM_ENGINES; n++)
        begin
            check_value($sformatf("error_count[%0d]", n), error_count[n], exp_err[n]);
        end

        $display("Summary: %0d runs, %0d checks, %0d errors", runs, checks, errors);
        if (errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
lb_pkg.sv
axi_skid_buffer.sv
lb_test_engine.sv
lb_mux_fixed.sv
host_mem_model.sv
lb_exerciser_top.sv
tb_lb_exerciser.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the loopback exerciser testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_lb_exerciser -o sim_lb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_lb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
